/* alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu #(
    parameter int xlen = 64
) (
    input  wire  [xlen-1:0]       a,
    input  wire  [xlen-1:0]       b,
    input  wire  rv_pkg::alu_op_t op,
    output logic [xlen-1:0]       y,
    output rv_pkg::flags_t        flags
);

    logic            subtract;
    logic [xlen-1:0] b_eff;
    logic [xlen-1:0] sum;
    logic            carry;
    logic            overflow;
    logic            less;
    logic            less_unsigned;

    // Compares run through the adder as a - b
    assign subtract = (op == rv_pkg::alu_sub) || (op == rv_pkg::alu_slt) ||
                      (op == rv_pkg::alu_sltu);
    assign b_eff = b ^ {xlen{subtract}};
    assign {carry, sum} = {1'b0, a} + {1'b0, b_eff} + {{xlen{1'b0}}, subtract};

    assign overflow = (a[xlen-1] == b_eff[xlen-1]) && (sum[xlen-1] != a[xlen-1]);
    assign less = sum[xlen-1] ^ overflow;
    // No carry out of a - b means a borrow
    assign less_unsigned = ~carry;

    always_comb begin
        case (op)
            rv_pkg::alu_and:  y = a & b;
            rv_pkg::alu_or:   y = a | b;
            rv_pkg::alu_xor:  y = a ^ b;
            rv_pkg::alu_slt:  y = {{(xlen-1){1'b0}}, less};
            rv_pkg::alu_sltu: y = {{(xlen-1){1'b0}}, less_unsigned};
            default:          y = sum;
        endcase
    end

    assign flags.zero     = (y == '0);
    assign flags.negative = y[xlen-1];
    assign flags.carry    = carry;
    assign flags.overflow = overflow;

endmodule

`default_nettype wire

/* control_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module control_unit (
    input  wire  reset,
    input  wire  rv_pkg::opcode_t opcode,
    input  wire  [2:0] func3,
    input  wire  funct7_5,
    input  wire  rv_pkg::flags_t flags,
    output rv_pkg::ctrl_t ctrl
);

    logic signed_less;
    logic branch_taken;

    // ALU op from func3, sub only for R-type with bit 30 set
    function automatic rv_pkg::alu_op_t decode_op(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  return sub ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b010:  return rv_pkg::alu_slt;
            3'b011:  return rv_pkg::alu_sltu;
            3'b100:  return rv_pkg::alu_xor;
            3'b110:  return rv_pkg::alu_or;
            3'b111:  return rv_pkg::alu_and;
            default: return rv_pkg::alu_add;
        endcase
    endfunction

    // Flags come from rs1 - rs2
    assign signed_less = flags.negative ^ flags.overflow;

    always_comb begin
        case (func3)
            3'b000:  branch_taken = flags.zero;
            3'b001:  branch_taken = ~flags.zero;
            3'b100:  branch_taken = signed_less;
            3'b101:  branch_taken = ~signed_less;
            3'b110:  branch_taken = ~flags.carry;
            3'b111:  branch_taken = flags.carry;
            default: branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = rv_pkg::alu_add;
        ctrl.wb_src = rv_pkg::wb_alu;
        case (opcode)
            rv_pkg::op_lui: begin
                ctrl.alu_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            rv_pkg::op_auipc: begin
                ctrl.alu_a_pc  = 1'b1;
                ctrl.alu_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            rv_pkg::op_jal: begin
                ctrl.wb_src      = rv_pkg::wb_pc4;
                ctrl.reg_write   = 1'b1;
                ctrl.take_target = 1'b1;
            end
            rv_pkg::op_jalr: begin
                ctrl.alu_b_imm   = 1'b1;
                ctrl.wb_src      = rv_pkg::wb_pc4;
                ctrl.reg_write   = 1'b1;
                ctrl.take_target = 1'b1;
                ctrl.jalr        = 1'b1;
            end
            rv_pkg::op_branch: begin
                ctrl.alu_op      = rv_pkg::alu_sub;
                ctrl.take_target = branch_taken;
            end
            rv_pkg::op_load: begin
                ctrl.alu_b_imm = 1'b1;
                ctrl.wb_src    = rv_pkg::wb_mem;
                ctrl.reg_write = 1'b1;
            end
            rv_pkg::op_store: begin
                ctrl.alu_b_imm = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            rv_pkg::op_imm: begin
                ctrl.alu_b_imm = 1'b1;
                ctrl.alu_op    = decode_op(func3, 1'b0);
                ctrl.reg_write = 1'b1;
            end
            rv_pkg::op_reg: begin
                ctrl.alu_op    = decode_op(func3, funct7_5);
                ctrl.reg_write = 1'b1;
            end
            rv_pkg::op_imm_w: begin
                ctrl.alu_b_imm = 1'b1;
                ctrl.word_op   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            rv_pkg::op_reg_w: begin
                ctrl.alu_op    = funct7_5 ? rv_pkg::alu_sub : rv_pkg::alu_add;
                ctrl.word_op   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            default: begin
                ctrl.reg_write = 1'b0;
            end
        endcase
        // No register or memory writes during reset
        if (reset) begin
            ctrl.reg_write = 1'b0;
            ctrl.mem_write = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* dataflow.sv */
`timescale 1ns/100ps
`default_nettype none

module dataflow #(
    parameter int xlen = 64
) (
    input  wire             clock,
    input  wire             reset,
    input  wire  [31:0]     instruction,
    input  wire  rv_pkg::ctrl_t ctrl,
    input  wire  [xlen-1:0] read_data,
    output logic [xlen-1:0] instruction_address,
    output logic [xlen-1:0] data_address,
    output logic [xlen-1:0] write_data,
    output rv_pkg::opcode_t opcode,
    output logic [2:0]      func3,
    output logic            funct7_5,
    output rv_pkg::flags_t  flags
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus_4;
    logic [xlen-1:0] next_pc;
    logic [4:0]      rs1_address;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [63:0]     immediate;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_y;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] wb_data;
    logic [xlen-1:0] target_base;
    logic [xlen-1:0] target_sum;
    logic [xlen-1:0] target;

    assign opcode   = rv_pkg::opcode_t'(instruction[6:0]);
    assign func3    = instruction[14:12];
    assign funct7_5 = instruction[30];

    // lui adds its immediate to x0
    assign rs1_address = (opcode == rv_pkg::op_lui) ? 5'd0 : instruction[19:15];

    register_file #(.xlen(xlen)) register_file_inst (
        .clock         (clock),
        .reset         (reset),
        .write_enable  (ctrl.reg_write),
        .read_address1 (rs1_address),
        .read_address2 (instruction[24:20]),
        .write_address (instruction[11:7]),
        .write_data    (wb_data),
        .read_data1    (rs1_data),
        .read_data2    (rs2_data)
    );

    imm_gen imm_gen_inst (
        .instruction (instruction),
        .immediate   (immediate)
    );

    assign imm = immediate[xlen-1:0];

    // Operand muxes
    assign alu_a = ctrl.alu_a_pc ? pc : rs1_data;
    assign alu_b = ctrl.alu_b_imm ? imm : rs2_data;

    alu #(.xlen(xlen)) alu_inst (
        .a     (alu_a),
        .b     (alu_b),
        .op    (ctrl.alu_op),
        .y     (alu_y),
        .flags (flags)
    );

    // W ops keep the low word, sign-extended
    assign alu_result = ctrl.word_op ? {{(xlen-32){alu_y[31]}}, alu_y[31:0]} : alu_y;

    always_comb begin
        case (ctrl.wb_src)
            rv_pkg::wb_mem: wb_data = read_data;
            rv_pkg::wb_pc4: wb_data = pc_plus_4;
            default:        wb_data = alu_result;
        endcase
    end

    // Jump and branch target, jalr clears bit 0
    assign target_base = ctrl.jalr ? rs1_data : pc;
    assign target_sum  = target_base + imm;
    assign target      = {target_sum[xlen-1:1], target_sum[0] & ~ctrl.jalr};

    assign pc_plus_4 = pc + xlen'(4);
    assign next_pc   = ctrl.take_target ? target : pc_plus_4;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    assign instruction_address = pc;
    assign data_address        = alu_y;
    assign write_data          = rs2_data;

endmodule

`default_nettype wire

/* files.f */
rv_pkg.sv
register_file.sv
alu.sv
imm_gen.sv
dataflow.sv
control_unit.sv
rv_core.sv
rv_core_props.sv
tb_rv_core.sv

/* imm_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module imm_gen (
    input  wire  [31:0] instruction,
    output logic [63:0] immediate
);

    rv_pkg::opcode_t opcode;

    assign opcode = rv_pkg::opcode_t'(instruction[6:0]);

    always_comb begin
        case (opcode)
            // S-type
            rv_pkg::op_store:
                immediate = {{52{instruction[31]}}, instruction[31:25], instruction[11:7]};
            // B-type, bit 0 always zero
            rv_pkg::op_branch:
                immediate = {{51{instruction[31]}}, instruction[31], instruction[7],
                             instruction[30:25], instruction[11:8], 1'b0};
            rv_pkg::op_lui,
            rv_pkg::op_auipc:
                immediate = {{32{instruction[31]}}, instruction[31:12], 12'b0};
            // J-type
            rv_pkg::op_jal:
                immediate = {{43{instruction[31]}}, instruction[31], instruction[19:12],
                             instruction[20], instruction[30:21], 1'b0};
            // I-type covers loads, jalr and immediate ALU ops
            default:
                immediate = {{52{instruction[31]}}, instruction[31:20]};
        endcase
    end

endmodule

`default_nettype wire

/* register_file.sv */
`timescale 1ns/100ps
`default_nettype none

module register_file #(
    parameter int xlen = 64
) (
    input  wire              clock,
    input  wire              reset,
    input  wire              write_enable,
    input  wire  [4:0]       read_address1,
    input  wire  [4:0]       read_address2,
    input  wire  [4:0]       write_address,
    input  wire  [xlen-1:0]  write_data,
    output logic [xlen-1:0]  read_data1,
    output logic [xlen-1:0]  read_data2
);

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && (write_address != 5'd0)) begin
            regs[write_address] <= write_data;
        end
    end

    // x0 reads as zero no matter what
    assign read_data1 = (read_address1 == 5'd0) ? '0 : regs[read_address1];
    assign read_data2 = (read_address2 == 5'd0) ? '0 : regs[read_address2];

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f files.f --top-module tb_rv_core -o sim_rv_core
./obj_dir/sim_rv_core +verilator+error+limit+100 | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if ! grep -q '\*\* PASS \*\*' sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation finished without errors"

/* rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core #(
    parameter int xlen = 64
) (
    input  wire             clock,
    input  wire             reset,
    input  wire  [31:0]     instruction,
    output logic [xlen-1:0] instruction_address,
    input  wire  [xlen-1:0] read_data,
    output logic [xlen-1:0] data_address,
    output logic [xlen-1:0] write_data,
    output logic            data_write
);

    rv_pkg::ctrl_t   ctrl;
    rv_pkg::opcode_t opcode;
    logic [2:0]      func3;
    logic            funct7_5;
    rv_pkg::flags_t  flags;

    dataflow #(.xlen(xlen)) dataflow_inst (
        .clock               (clock),
        .reset               (reset),
        .instruction         (instruction),
        .ctrl                (ctrl),
        .read_data           (read_data),
        .instruction_address (instruction_address),
        .data_address        (data_address),
        .write_data          (write_data),
        .opcode              (opcode),
        .func3               (func3),
        .funct7_5            (funct7_5),
        .flags               (flags)
    );

    control_unit control_unit_inst (
        .reset    (reset),
        .opcode   (opcode),
        .func3    (func3),
        .funct7_5 (funct7_5),
        .flags    (flags),
        .ctrl     (ctrl)
    );

    // Store strobe straight from the control word
    assign data_write = ctrl.mem_write;

endmodule

`default_nettype wire

/* rv_core_props.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core_props #(
    parameter int xlen = 64
) (
    input  wire                clock,
    input  wire                reset,
    input  wire rv_pkg::ctrl_t ctrl,
    input  wire  [xlen-1:0]    pc
);

    // Read by the testbench at the end of the run
    int unsigned failures = 0;

    // Control word must block all writes while in reset
    no_write_in_reset: assert property (
        @(posedge clock) reset |-> (!ctrl.reg_write && !ctrl.mem_write)
    ) else begin
        $error("register or memory write enabled while reset is high");
        failures++;
    end

    // PC comes out of reset at address 0
    pc_zero_after_reset: assert property (
        @(posedge clock) reset |=> (pc == '0)
    ) else begin
        $error("PC not zero one cycle after reset");
        failures++;
    end

endmodule

bind rv_core rv_core_props #(.xlen(xlen)) rv_core_props_inst (
    .clock      (clock),
    .reset      (reset),
    .ctrl       (ctrl),
    .pc         (instruction_address)
);

`default_nettype wire

/* rv_core_stimulus.txt */
// test instruction read_data expected_pc store store_address store_data
// One row per executed instruction in execution order, all values in hex
01 00500093 0000000000000000 00000000 0 0000000000000000 0000000000000000
01 ffd00113 0000000000000000 00000004 0 0000000000000000 0000000000000000
02 002081b3 0000000000000000 00000008 0 0000000000000000 0000000000000000
02 40208233 0000000000000000 0000000c 0 0000000000000000 0000000000000000
02 0041b023 0000000000000000 00000010 1 0000000000000002 0000000000000008
02 0020f2b3 0000000000000000 00000014 0 0000000000000000 0000000000000000
02 0020e333 0000000000000000 00000018 0 0000000000000000 0000000000000000
02 00533023 0000000000000000 0000001c 1 fffffffffffffffd 0000000000000005
02 0020c3b3 0000000000000000 00000020 0 0000000000000000 0000000000000000
02 00112433 0000000000000000 00000024 0 0000000000000000 0000000000000000
02 00743023 0000000000000000 00000028 1 0000000000000001 fffffffffffffff8
02 001134b3 0000000000000000 0000002c 0 0000000000000000 0000000000000000
02 00943823 0000000000000000 00000030 1 0000000000000011 0000000000000000
03 123455b7 0000000000000000 00000034 0 0000000000000000 0000000000000000
03 00001617 0000000000000000 00000038 0 0000000000000000 0000000000000000
03 00b63023 0000000000000000 0000003c 1 0000000000001038 0000000012345000
03 800006b7 0000000000000000 00000040 0 0000000000000000 0000000000000000
03 00d03023 0000000000000000 00000044 1 0000000000000000 ffffffff80000000
04 0080b703 0123456789abcdef 00000048 0 0000000000000000 0000000000000000
04 00708013 0000000000000000 0000004c 0 0000000000000000 0000000000000000
04 00073023 0000000000000000 00000050 1 0123456789abcdef 0000000000000000
05 00208463 0000000000000000 00000054 0 0000000000000000 0000000000000000
05 00108463 0000000000000000 00000058 0 0000000000000000 0000000000000000
05 00109463 0000000000000000 00000060 0 0000000000000000 0000000000000000
05 00209463 0000000000000000 00000064 0 0000000000000000 0000000000000000
05 0020c463 0000000000000000 0000006c 0 0000000000000000 0000000000000000
05 00114463 0000000000000000 00000070 0 0000000000000000 0000000000000000
05 00115463 0000000000000000 00000078 0 0000000000000000 0000000000000000
05 0020d463 0000000000000000 0000007c 0 0000000000000000 0000000000000000
05 0020e463 0000000000000000 00000084 0 0000000000000000 0000000000000000
05 00116463 0000000000000000 0000008c 0 0000000000000000 0000000000000000
05 0020f463 0000000000000000 00000090 0 0000000000000000 0000000000000000
05 00117463 0000000000000000 00000094 0 0000000000000000 0000000000000000
05 010007ef 0000000000000000 0000009c 0 0000000000000000 0000000000000000
05 01978867 0000000000000000 000000ac 0 0000000000000000 0000000000000000
05 00f83023 0000000000000000 000000b8 1 00000000000000b0 00000000000000a0
06 7ffff8b7 0000000000000000 000000bc 0 0000000000000000 0000000000000000
06 011889bb 0000000000000000 000000c0 0 0000000000000000 0000000000000000
06 40d00a3b 0000000000000000 000000c4 0 0000000000000000 0000000000000000
06 013a3023 0000000000000000 000000c8 1 ffffffff80000000 ffffffffffffe000

/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // Base opcodes, instruction bits [6:0]
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_imm_w  = 7'b0011011,
        op_reg_w  = 7'b0111011
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu
    } alu_op_t;

    // Value written back to rd
    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc4
    } wb_src_t;

    typedef struct packed {
        logic    alu_a_pc;
        logic    alu_b_imm;
        alu_op_t alu_op;
        logic    word_op;
        wb_src_t wb_src;
        logic    reg_write;
        logic    mem_write;
        logic    take_target;
        logic    jalr;
    } ctrl_t;

    typedef struct packed {
        logic zero;
        logic negative;
        logic carry;
        logic overflow;
    } flags_t;

endpackage

`default_nettype wire

/* tb_rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;

    localparam int xlen         = 64;
    localparam int clock_period = 40;
    localparam int reset_cycles = 10;
    localparam int max_rows     = 64;
    // Columns per row in the stimulus file
    localparam int fields       = 7;

    logic              clock;
    logic              reset;
    logic [31:0]       instruction;
    logic [xlen-1:0]   read_data;
    wire  [xlen-1:0]   instruction_address;
    wire  [xlen-1:0]   data_address;
    wire  [xlen-1:0]   write_data;
    wire               data_write;

    logic [63:0] stimulus [fields*max_rows];
    int row_count = 0;
    int test_errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    rv_core #(.xlen(xlen)) rv_core_inst (
        .clock               (clock),
        .reset               (reset),
        .instruction         (instruction),
        .instruction_address (instruction_address),
        .read_data           (read_data),
        .data_address        (data_address),
        .write_data          (write_data),
        .data_write          (data_write)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period/2) clock = ~clock;
    end

    function automatic logic [63:0] row_field(input int row, input int index);
        return stimulus[row*fields + index];
    endfunction

    task automatic check_addr(input string name, input logic [xlen-1:0] actual,
                              input logic [xlen-1:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            test_errors++;
        end
    endtask

    task automatic check_data(input string name, input logic [xlen-1:0] actual,
                              input logic [xlen-1:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            test_errors++;
        end
    endtask

    task automatic check_strobe(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
            test_errors++;
        end
    endtask

    // Plays instruction memory and data memory for one cycle
    task automatic drive_row(input int row);
        logic [63:0] word;
        word = row_field(row, 1);
        instruction <= word[31:0];
        read_data   <= row_field(row, 2);
    endtask

    task automatic check_row(input int row);
        logic [63:0] strobe_word;
        strobe_word = row_field(row, 4);
        check_addr("instruction_address", instruction_address, row_field(row, 3));
        check_strobe("data_write", data_write, strobe_word[0]);
        if (strobe_word[0]) begin
            check_addr("data_address", data_address, row_field(row, 5));
            check_data("write_data", write_data, row_field(row, 6));
        end
    endtask

    task automatic close_test(input int number);
        if (test_errors == 0) begin
            $display("Test %0d passed", number);
            tests_passed++;
        end else begin
            $display("Test %0d failed with %0d errors", number, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    // Run limit scales with the number of stimulus rows
    initial begin
        wait (row_count > 0);
        #((row_count + 20) * clock_period);
        $display("Timeout: the run did not end within %0d clock cycles", row_count + 20);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        // sd x0, 0(x0) on the bus, so reset has a store to block
        instruction = 32'h0000_3023;
        read_data   = '0;
        $readmemh("rv_core_stimulus.txt", stimulus);
        // Valid test numbers run from 1 to 254
        while (row_count < max_rows && stimulus[row_count*fields] >= 64'd1 &&
               stimulus[row_count*fields] <= 64'd254) begin
            row_count++;
        end
        if (row_count == 0) begin
            $display("No rows could be read from rv_core_stimulus.txt");
            tests_failed++;
        end

        // Strobe must stay low through reset
        repeat (reset_cycles - 1) begin
            @(negedge clock);
            check_strobe("data_write", data_write, 1'b0);
        end
        @(posedge clock);
        reset <= 1'b0;
        if (row_count > 0) begin
            drive_row(0);
        end

        for (int r = 0; r < row_count; r++) begin
            @(negedge clock);
            check_row(r);
            if (r + 1 == row_count || row_field(r + 1, 0) != row_field(r, 0)) begin
                close_test(int'(row_field(r, 0)));
            end
            @(posedge clock);
            if (r + 1 < row_count) begin
                drive_row(r + 1);
            end
        end

        if (rv_core_inst.rv_core_props_inst.failures != 0) begin
            $display("Bound assertions failed %0d times",
                     rv_core_inst.rv_core_props_inst.failures);
            tests_failed++;
        end
        $display("Tests passed: %0d  failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
